/* mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

`default_nettype none

// data word width in bits.
`define MEM_WIDTH 16
// word address width for 256 words.
`define MEM_ADDR_BITS 8
// low address bits that pick one of four banks.
`define MEM_BANK_BITS 2
// upper address bits that pick one of 64 rows in a bank.
`define MEM_ROW_BITS 6
// each read port owns one replica of the bank set.
`define MEM_RD_PORTS 2
// read latency of one SRAM bank in cycles.
`define MEM_SRAM_DELAY 2

`default_nettype wire

`endif

/* mem_phys_pkg.sv */
`include "mem_macros.svh"
`default_nettype none

package mem_phys_pkg;

  // bank number, taken from the low address bits.
  typedef logic [`MEM_BANK_BITS-1:0] bank_t;

  // row inside a bank, taken from the upper address bits.
  typedef logic [`MEM_ROW_BITS-1:0] row_t;

  // replica index, which equals the number of the read port that owns it.
  typedef logic [$clog2(`MEM_RD_PORTS)-1:0] replica_t;

  // physical location of a word as reported with each read.
  typedef struct packed {
    replica_t replica;
    bank_t    bank;
    row_t     row;
  } padr_t;

endpackage

`default_nettype wire

/* mem_data_pkg.sv */
`include "mem_macros.svh"
`default_nettype none

package mem_data_pkg;

  typedef logic [`MEM_WIDTH-1:0] data_t;      // one stored word.
  typedef logic [`MEM_ADDR_BITS-1:0] addr_t;  // logical word address.

  // side information of a read while it waits for the SRAM.
  // when fwd is set the word in data replaces what the bank returns.
  typedef struct packed {
    logic                vld;
    logic                fwd;
    data_t               data;
    mem_phys_pkg::padr_t padr;
  } rd_tag_t;

endpackage

`default_nettype wire

/* mem_delay_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_delay_pipe #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire payload_t in,
  output payload_t      out
);

  payload_t stage_q [DEPTH];  // stage 0 is the youngest entry.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;  // drops every entry in flight.
      end
    end else begin
      stage_q[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out = stage_q[DEPTH-1];

endmodule

`default_nettype wire

/* mem_sram_1r1w.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_sram_1r1w #(
  parameter int DELAY = `MEM_SRAM_DELAY
) (
  input  wire logic                clk,
  input  wire logic                wr_en,
  input  wire mem_phys_pkg::row_t  wr_row,
  input  wire mem_data_pkg::data_t wr_data,
  input  wire logic                rd_en,
  input  wire mem_phys_pkg::row_t  rd_row,
  output mem_data_pkg::data_t      rd_data
);

  localparam int NUM_ROWS = 1 << `MEM_ROW_BITS;

  mem_data_pkg::data_t mem [NUM_ROWS];
  mem_data_pkg::data_t dout_q [DELAY];  // output register chain.

  // Both updates are nonblocking, so a read of the row being written
  // returns the word stored before this edge.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dout_q[0] <= mem[rd_row];  // holds its value between reads.
    end
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
    for (int i = 1; i < DELAY; i++) begin
      dout_q[i] <= dout_q[i-1];
    end
  end

  assign rd_data = dout_q[DELAY-1];

endmodule

`default_nettype wire

/* mem_cmd_stage.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_cmd_stage (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     write,
  input  wire mem_data_pkg::addr_t      wr_adr,
  input  wire mem_data_pkg::data_t      din,
  input  wire logic [`MEM_RD_PORTS-1:0] read,
  input  wire mem_data_pkg::addr_t      rd_adr0,
  input  wire mem_data_pkg::addr_t      rd_adr1,
  output logic                          ready,
  output logic                          wr_en,
  output mem_phys_pkg::bank_t           wr_bank,
  output logic                          wr_all_banks,
  output mem_phys_pkg::row_t            wr_row,
  output mem_data_pkg::data_t           wr_data,
  output logic [`MEM_RD_PORTS-1:0]      rd_en,
  output mem_phys_pkg::bank_t           rd_bank0,
  output mem_phys_pkg::bank_t           rd_bank1,
  output mem_phys_pkg::row_t            rd_row0,
  output mem_phys_pkg::row_t            rd_row1,
  output mem_data_pkg::rd_tag_t         tag0,
  output mem_data_pkg::rd_tag_t         tag1
);

  mem_phys_pkg::row_t       sweep_row;  // next row to clear after reset.
  logic [`MEM_RD_PORTS-1:0] fwd_q;      // read hits the write of its own cycle.

  function automatic mem_phys_pkg::bank_t adr_bank(input mem_data_pkg::addr_t adr);
    return adr[`MEM_BANK_BITS-1:0];
  endfunction

  function automatic mem_phys_pkg::row_t adr_row(input mem_data_pkg::addr_t adr);
    return adr[`MEM_ADDR_BITS-1:`MEM_BANK_BITS];
  endfunction

  // while ready is low the stage owns the write port and clears one row per cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      ready        <= 1'b0;
      sweep_row    <= '0;
      wr_en        <= 1'b0;
      wr_all_banks <= 1'b0;
      rd_en        <= '0;
    end else if (!ready) begin
      wr_en        <= 1'b1;
      wr_all_banks <= 1'b1;  // one row of every bank per cycle.
      rd_en        <= '0;
      sweep_row    <= sweep_row + 1'b1;
      if (sweep_row == '1) begin
        ready <= 1'b1;  // the last row goes out together with ready.
      end
    end else begin
      wr_en        <= write;
      wr_all_banks <= 1'b0;
      rd_en        <= read;
    end
  end

  always_ff @(posedge clk) begin
    wr_bank  <= adr_bank(wr_adr);
    wr_row   <= ready ? adr_row(wr_adr) : sweep_row;
    wr_data  <= ready ? din : '0;
    rd_bank0 <= adr_bank(rd_adr0);
    rd_bank1 <= adr_bank(rd_adr1);
    rd_row0  <= adr_row(rd_adr0);
    rd_row1  <= adr_row(rd_adr1);
    fwd_q[0] <= write && (wr_adr == rd_adr0);
    fwd_q[1] <= write && (wr_adr == rd_adr1);
  end

  // The registered write word doubles as the forwarded data.
  assign tag0 = '{vld: rd_en[0], fwd: fwd_q[0], data: wr_data,
                  padr: '{replica: mem_phys_pkg::replica_t'(0), bank: rd_bank0, row: rd_row0}};
  assign tag1 = '{vld: rd_en[1], fwd: fwd_q[1], data: wr_data,
                  padr: '{replica: mem_phys_pkg::replica_t'(1), bank: rd_bank1, row: rd_row1}};

endmodule

`default_nettype wire

/* mem_bank_array.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_bank_array (
  input  wire logic                     clk,
  input  wire logic                     wr_en,
  input  wire mem_phys_pkg::bank_t      wr_bank,
  input  wire logic                     wr_all_banks,
  input  wire mem_phys_pkg::row_t       wr_row,
  input  wire mem_data_pkg::data_t      wr_data,
  input  wire logic [`MEM_RD_PORTS-1:0] rd_en,
  input  wire mem_phys_pkg::bank_t      rd_bank0,
  input  wire mem_phys_pkg::bank_t      rd_bank1,
  input  wire mem_phys_pkg::row_t       rd_row0,
  input  wire mem_phys_pkg::row_t       rd_row1,
  output mem_data_pkg::data_t           rd_data0,
  output mem_data_pkg::data_t           rd_data1
);

  localparam int NUM_BANKS = 1 << `MEM_BANK_BITS;

  mem_phys_pkg::bank_t rd_bank [`MEM_RD_PORTS];
  mem_phys_pkg::row_t  rd_row [`MEM_RD_PORTS];
  mem_data_pkg::data_t port_dout [`MEM_RD_PORTS];

  assign rd_bank[0] = rd_bank0;
  assign rd_bank[1] = rd_bank1;
  assign rd_row[0]  = rd_row0;
  assign rd_row[1]  = rd_row1;

  // one replica per read port; the write reaches the same bank in all of them.
  for (genvar r = 0; r < `MEM_RD_PORTS; r++) begin : g_replica
    mem_data_pkg::data_t bank_dout [NUM_BANKS];
    mem_phys_pkg::bank_t bank_q [`MEM_SRAM_DELAY];  // bank of the read in flight.

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      logic bank_wr_en;
      logic bank_rd_en;

      assign bank_wr_en = wr_en && (wr_all_banks || wr_bank == mem_phys_pkg::bank_t'(b));
      assign bank_rd_en = rd_en[r] && rd_bank[r] == mem_phys_pkg::bank_t'(b);

      mem_sram_1r1w #(
        .DELAY(`MEM_SRAM_DELAY)
      ) sram_i (
        .clk    (clk),
        .wr_en  (bank_wr_en),
        .wr_row (wr_row),
        .wr_data(wr_data),
        .rd_en  (bank_rd_en),
        .rd_row (rd_row[r]),
        .rd_data(bank_dout[b])
      );
    end

    // The bank number walks the same number of stages as the SRAM output.
    always_ff @(posedge clk) begin
      bank_q[0] <= rd_bank[r];
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        bank_q[i] <= bank_q[i-1];
      end
    end

    assign port_dout[r] = bank_dout[bank_q[`MEM_SRAM_DELAY-1]];
  end

  assign rd_data0 = port_dout[0];
  assign rd_data1 = port_dout[1];

endmodule

`default_nettype wire

/* mem_rd_out_stage.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_rd_out_stage (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire mem_data_pkg::rd_tag_t  tag0,
  input  wire mem_data_pkg::rd_tag_t  tag1,
  input  wire mem_data_pkg::data_t    rd_data0,
  input  wire mem_data_pkg::data_t    rd_data1,
  output logic [`MEM_RD_PORTS-1:0]    rd_vld,
  output mem_data_pkg::data_t         rd_dout0,
  output mem_data_pkg::data_t         rd_dout1,
  output mem_phys_pkg::padr_t         rd_padr0,
  output mem_phys_pkg::padr_t         rd_padr1
);

  // a forwarded word is newer than anything the bank can return.
  function automatic mem_data_pkg::data_t pick_data(input mem_data_pkg::rd_tag_t tag,
                                                    input mem_data_pkg::data_t   bank_data);
    return tag.fwd ? tag.data : bank_data;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= {tag1.vld, tag0.vld};
    end
  end

  always_ff @(posedge clk) begin
    rd_dout0 <= pick_data(tag0, rd_data0);
    rd_dout1 <= pick_data(tag1, rd_data1);
    rd_padr0 <= tag0.padr;
    rd_padr1 <= tag1.padr;
  end

endmodule

`default_nettype wire

/* mem_2r1w_top.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_2r1w_top (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     write,
  input  wire mem_data_pkg::addr_t      wr_adr,
  input  wire mem_data_pkg::data_t      din,
  input  wire logic [`MEM_RD_PORTS-1:0] read,
  input  wire mem_data_pkg::addr_t      rd_adr0,
  input  wire mem_data_pkg::addr_t      rd_adr1,
  output logic                          ready,
  output logic [`MEM_RD_PORTS-1:0]      rd_vld,
  output mem_data_pkg::data_t           rd_dout0,
  output mem_data_pkg::data_t           rd_dout1,
  output mem_phys_pkg::padr_t           rd_padr0,
  output mem_phys_pkg::padr_t           rd_padr1
);

  logic                     wr_en;
  mem_phys_pkg::bank_t      wr_bank;
  logic                     wr_all_banks;
  mem_phys_pkg::row_t       wr_row;
  mem_data_pkg::data_t      wr_data;
  logic [`MEM_RD_PORTS-1:0] rd_en;
  mem_phys_pkg::bank_t      rd_bank0;
  mem_phys_pkg::bank_t      rd_bank1;
  mem_phys_pkg::row_t       rd_row0;
  mem_phys_pkg::row_t       rd_row1;
  mem_data_pkg::rd_tag_t    tag0;          // tags as they leave stage 1.
  mem_data_pkg::rd_tag_t    tag1;
  mem_data_pkg::rd_tag_t    tag0_dly;      // tags lined up with the bank data.
  mem_data_pkg::rd_tag_t    tag1_dly;
  mem_data_pkg::data_t      rd_data0;
  mem_data_pkg::data_t      rd_data1;

  mem_cmd_stage cmd_stage_i (
    .clk(clk), .reset(reset), .write(write), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_adr0(rd_adr0), .rd_adr1(rd_adr1), .ready(ready),
    .wr_en(wr_en), .wr_bank(wr_bank), .wr_all_banks(wr_all_banks), .wr_row(wr_row),
    .wr_data(wr_data), .rd_en(rd_en), .rd_bank0(rd_bank0), .rd_bank1(rd_bank1),
    .rd_row0(rd_row0), .rd_row1(rd_row1), .tag0(tag0), .tag1(tag1)
  );

  mem_bank_array bank_array_i (
    .clk(clk), .wr_en(wr_en), .wr_bank(wr_bank), .wr_all_banks(wr_all_banks),
    .wr_row(wr_row), .wr_data(wr_data), .rd_en(rd_en), .rd_bank0(rd_bank0),
    .rd_bank1(rd_bank1), .rd_row0(rd_row0), .rd_row1(rd_row1),
    .rd_data0(rd_data0), .rd_data1(rd_data1)
  );

  mem_delay_pipe #(.DEPTH(`MEM_SRAM_DELAY), .payload_t(mem_data_pkg::rd_tag_t)) tag0_pipe_i (
    .clk(clk), .reset(reset), .in(tag0), .out(tag0_dly)
  );

  mem_delay_pipe #(.DEPTH(`MEM_SRAM_DELAY), .payload_t(mem_data_pkg::rd_tag_t)) tag1_pipe_i (
    .clk(clk), .reset(reset), .in(tag1), .out(tag1_dly)
  );

  mem_rd_out_stage rd_out_stage_i (
    .clk(clk), .reset(reset), .tag0(tag0_dly), .tag1(tag1_dly),
    .rd_data0(rd_data0), .rd_data1(rd_data1), .rd_vld(rd_vld),
    .rd_dout0(rd_dout0), .rd_dout1(rd_dout1), .rd_padr0(rd_padr0), .rd_padr1(rd_padr1)
  );

endmodule

`default_nettype wire

/* mem_2r1w_asserts.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module mem_2r1w_asserts (
  input wire logic                     clk,
  input wire logic                     reset,
  input wire logic [`MEM_RD_PORTS-1:0] read,
  input wire logic                     ready,
  input wire logic [`MEM_RD_PORTS-1:0] rd_vld
);

  logic [`MEM_RD_PORTS-1:0] read_taken;  // reads are dropped while ready is low.

  assign read_taken = ready ? read : '0;

  no_vld_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> rd_vld == '0)
    else $error("rd_vld high during reset");

  ready_stays_high: assert property (@(posedge clk) disable iff (reset) ready |=> ready)
    else $error("ready dropped after rising");

  // stage 1, the SRAM delay and stage 3 add up to four cycles.
  vld_follows_read: assert property (@(posedge clk) disable iff (reset)
                                     rd_vld == $past(read_taken, 4))
    else $error("rd_vld does not follow read by four cycles");

endmodule

bind mem_2r1w_top mem_2r1w_asserts asserts_i (
  .clk(clk), .reset(reset), .read(read), .ready(ready), .rd_vld(rd_vld)
);

`default_nettype wire

/* tb_mem_2r1w.sv */
`timescale 1ns/100ps
`include "mem_macros.svh"
`default_nettype none

module tb_mem_2r1w;

  localparam int NUM_WORDS     = 1 << `MEM_ADDR_BITS;
  localparam int NUM_BANKS     = 1 << `MEM_BANK_BITS;
  localparam int RD_LATENCY    = 4;  // cycles from a read strobe to its rd_vld.
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 40;
  localparam int MIXED_CYCLES  = 400;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     write;
  mem_data_pkg::addr_t      wr_adr;
  mem_data_pkg::data_t      din;
  logic [`MEM_RD_PORTS-1:0] read;
  mem_data_pkg::addr_t      rd_adr0;
  mem_data_pkg::addr_t      rd_adr1;
  logic                     ready;
  logic [`MEM_RD_PORTS-1:0] rd_vld;
  mem_data_pkg::data_t      rd_dout0;
  mem_data_pkg::data_t      rd_dout1;
  mem_phys_pkg::padr_t      rd_padr0;
  mem_phys_pkg::padr_t      rd_padr1;

  int unsigned cycle_cnt  = 0;
  bit          ready_seen = 1'b0;

  mem_data_pkg::data_t model_mem [NUM_WORDS];  // memory contents as the DUT should hold them.
  mem_data_pkg::data_t exp_data0 [$];
  mem_data_pkg::data_t exp_data1 [$];
  mem_phys_pkg::padr_t exp_padr0 [$];
  mem_phys_pkg::padr_t exp_padr1 [$];
  int unsigned         exp_cycle0 [$];  // cycle in which each read was driven.
  int unsigned         exp_cycle1 [$];

  mem_2r1w_top mem_2r1w_top_i (
    .clk(clk), .reset(reset), .write(write), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_adr0(rd_adr0), .rd_adr1(rd_adr1), .ready(ready),
    .rd_vld(rd_vld), .rd_dout0(rd_dout0), .rd_dout1(rd_dout1),
    .rd_padr0(rd_padr0), .rd_padr1(rd_padr1)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_data(input string name, input mem_data_pkg::data_t got,
                            input mem_data_pkg::data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_padr(input string name, input mem_phys_pkg::padr_t got,
                            input mem_phys_pkg::padr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // the bank is the word address modulo the bank count and the row is the quotient.
  function automatic void ref_read(input int port, input mem_data_pkg::addr_t adr,
                                   output mem_data_pkg::data_t data,
                                   output mem_phys_pkg::padr_t padr);
    data         = model_mem[adr];
    padr.replica = mem_phys_pkg::replica_t'(port);
    padr.bank    = mem_phys_pkg::bank_t'(adr % NUM_BANKS);
    padr.row     = mem_phys_pkg::row_t'(adr / NUM_BANKS);
  endfunction

  function automatic mem_data_pkg::addr_t random_addr();
    return mem_data_pkg::addr_t'($urandom_range(NUM_WORDS - 1, 0));
  endfunction

  // a narrow range makes reads hit recent writes often.
  function automatic mem_data_pkg::addr_t narrow_addr();
    return mem_data_pkg::addr_t'($urandom_range(63, 0));
  endfunction

  function automatic mem_data_pkg::data_t random_data();
    return mem_data_pkg::data_t'($urandom());
  endfunction

  task automatic drive_cycle(input logic                     wr,
                             input mem_data_pkg::addr_t      wa,
                             input mem_data_pkg::data_t      wd,
                             input logic [`MEM_RD_PORTS-1:0] rd,
                             input mem_data_pkg::addr_t      ra0,
                             input mem_data_pkg::addr_t      ra1);
    mem_data_pkg::data_t d;
    mem_phys_pkg::padr_t p;
    @(posedge clk);
    #1;
    write   = wr;
    wr_adr  = wa;
    din     = wd;
    read    = rd;
    rd_adr0 = ra0;
    rd_adr1 = ra1;
    if (wr) begin
      model_mem[wa] = wd;  // reads of this same cycle already see the new word.
    end
    if (rd[0]) begin
      ref_read(0, ra0, d, p);
      exp_data0.push_back(d);
      exp_padr0.push_back(p);
      exp_cycle0.push_back(cycle_cnt);
    end
    if (rd[1]) begin
      ref_read(1, ra1, d, p);
      exp_data1.push_back(d);
      exp_padr1.push_back(p);
      exp_cycle1.push_back(cycle_cnt);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1 && n < READY_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ready !== 1'b1) begin
      report_failure("ready did not rise after reset within the timeout");
    end
  endtask

  task automatic wait_drain(output bit drained);
    int n;
    n = 0;
    while ((exp_cycle0.size() != 0 || exp_cycle1.size() != 0) && n < DRAIN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    drained = (exp_cycle0.size() == 0 && exp_cycle1.size() == 0);
  endtask

  task automatic compare_port(input int port, input logic vld);
    mem_data_pkg::data_t exp_d;
    mem_phys_pkg::padr_t exp_p;
    int unsigned         issue;
    bit                  pending;
    pending = (port == 0) ? (exp_cycle0.size() != 0) : (exp_cycle1.size() != 0);
    if (vld && !pending) begin
      report_failure($sformatf("rd_vld[%0d] is high with no read outstanding", port));
    end else if (vld) begin
      if (port == 0) begin
        exp_d = exp_data0.pop_front();
        exp_p = exp_padr0.pop_front();
        issue = exp_cycle0.pop_front();
      end else begin
        exp_d = exp_data1.pop_front();
        exp_p = exp_padr1.pop_front();
        issue = exp_cycle1.pop_front();
      end
      if (cycle_cnt != issue + RD_LATENCY) begin
        report_failure($sformatf("port %0d returned the read of cycle %0d in cycle %0d",
                                 port, issue, cycle_cnt));
      end
      if (port == 0) begin
        check_data("rd_dout0", rd_dout0, exp_d);
        check_padr("rd_padr0", rd_padr0, exp_p);
      end else begin
        check_data("rd_dout1", rd_dout1, exp_d);
        check_padr("rd_padr1", rd_padr1, exp_p);
      end
    end else if (pending) begin
      issue = (port == 0) ? exp_cycle0[0] : exp_cycle1[0];
      if (cycle_cnt >= issue + RD_LATENCY) begin
        report_failure($sformatf("port %0d never raised rd_vld for the read of cycle %0d",
                                 port, issue));
      end
    end
  endtask

  // outputs change on the rising edge, so the falling edge sees them settled.
  always @(negedge clk) begin
    if (reset) begin
      if (rd_vld !== '0) begin
        report_failure("rd_vld is high while reset is asserted");
      end
    end else if (ready_seen && ready !== 1'b1) begin
      report_failure("ready fell after it had risen");
    end else begin
      ready_seen = ready_seen || (ready === 1'b1);
      compare_port(0, rd_vld[0]);
      compare_port(1, rd_vld[1]);
    end
  end

  initial begin
    mem_data_pkg::addr_t      wr_list [32];
    mem_data_pkg::addr_t      a;
    mem_data_pkg::addr_t      b;
    mem_data_pkg::data_t      d;
    logic [`MEM_RD_PORTS-1:0] rd_bits;
    bit                       drained;
    reset   = 1'b1;
    write   = 1'b0;
    wr_adr  = '0;
    din     = '0;
    read    = '0;
    rd_adr0 = '0;
    rd_adr1 = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      model_mem[i] = '0;  // the sweep after reset clears every word.
    end
    void'($urandom(35490));
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_ready();

    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b0, '0, '0, 2'b11, random_addr(), random_addr());
    end

    for (int i = 0; i < 32; i++) begin
      wr_list[i] = random_addr();
      drive_cycle(1'b1, wr_list[i], random_data(), 2'b00, '0, '0);
    end
    for (int i = 0; i < 32; i++) begin
      drive_cycle(1'b0, '0, '0, 2'b11, wr_list[i], wr_list[(i + 5) % 32]);
    end

    // both ports on one word, then both ports in one bank on different rows.
    for (int i = 0; i < 8; i++) begin
      a = random_addr();
      b = a + mem_data_pkg::addr_t'(NUM_BANKS * (1 + i));
      drive_cycle(1'b1, a, random_data(), 2'b00, '0, '0);
      drive_cycle(1'b1, b, random_data(), 2'b00, '0, '0);
      drive_cycle(1'b0, '0, '0, 2'b11, a, a);
      drive_cycle(1'b0, '0, '0, 2'b11, a, b);
    end

    for (int i = 0; i < 8; i++) begin
      a = random_addr();
      d = random_data();
      drive_cycle(1'b1, a, d, 2'b11, a, a);  // served by the forwarding path.
      drive_cycle(1'b0, '0, '0, 2'b11, a, a);
    end

    for (int i = 0; i < MIXED_CYCLES; i++) begin
      rd_bits = 2'($urandom_range(3, 0));
      drive_cycle($urandom_range(7, 0) != 0, narrow_addr(), random_data(), rd_bits,
                  narrow_addr(), narrow_addr());
    end

    drive_cycle(1'b0, '0, '0, 2'b00, '0, '0);
    wait_drain(drained);
    if (drained) begin
      $display("Done: no errors");
      $finish;
    end else begin
      report_failure("reads were still outstanding when the drain timeout expired");
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
mem_phys_pkg.sv
mem_data_pkg.sv
mem_delay_pipe.sv
mem_sram_1r1w.sv
mem_cmd_stage.sv
mem_bank_array.sv
mem_rd_out_stage.sv
mem_2r1w_top.sv
mem_2r1w_asserts.sv
tb_mem_2r1w.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_mem_2r1w -f src.f
out=$(./obj_dir/Vtb_mem_2r1w 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
